// ==== mips.f ====
rtl/mips_pkg.sv
rtl/program_loader.sv
rtl/instruction_fetch.sv
rtl/instruction_decode.sv
rtl/execution.sv
rtl/memory_access.sv
rtl/mips.sv
testbench/tb_mips_sva.sv
testbench/tb_mips.sv

// ==== Bender.yml ====
package:
  name: mips

sources:
  - rtl/mips_pkg.sv
  - rtl/program_loader.sv
  - rtl/instruction_fetch.sv
  - rtl/instruction_decode.sv
  - rtl/execution.sv
  - rtl/memory_access.sv
  - rtl/mips.sv
  - target: test
    files:
      - testbench/tb_mips_sva.sv
      - testbench/tb_mips.sv

// ==== testbench/tb_mips.sv ====
`timescale 1ns/1ps

module tb_mips;
    import mips_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int END_TIMEOUT = 200;               // Run cycles allowed per program

    // One table row holds a program slice and its expected results
    typedef struct packed {
        logic [7:0]  start;                         // First word in prog
        logic [7:0]  count;
        reg_addr_t   reg_addr;
        word_t       reg_val;
        logic        mem_chk;                       // 0 = no memory check
        logic [4:0]  mem_addr;                      // Word index
        word_t       mem_val;
        word_t       halt_pc;
    } test_row_t;

    logic       clock;
    logic       rst;
    logic       run;
    logic       pc_reset;
    logic       load_valid;
    logic [7:0] load_byte;
    reg_addr_t  debug_reg_addr;
    logic [4:0] debug_mem_addr;
    word_t      debug_read_reg;
    word_t      debug_read_mem;
    word_t      debug_read_pc;
    logic       is_program_end;

    word_t      prog [$];                           // All program words back to back
    test_row_t  rows [$];
    integer     seed;
    int         err_cnt  = 0;
    int         pass_cnt = 0;
    int         fail_cnt = 0;

    mips #(
        .NB_IMEM_ADDR (6),
        .NB_DMEM_ADDR (5)
    ) dut (
        .i_clock          (clock),
        .i_rst            (rst),
        .i_run            (run),
        .i_pc_reset       (pc_reset),
        .i_load_valid     (load_valid),
        .i_load_byte      (load_byte),
        .i_debug_reg_addr (debug_reg_addr),
        .i_debug_mem_addr (debug_mem_addr),
        .o_debug_read_reg (debug_read_reg),
        .o_debug_read_mem (debug_read_mem),
        .o_debug_read_pc  (debug_read_pc),
        .o_is_program_end (is_program_end)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // ----------------------------------------------------------------------
    // Instruction encoding and table building
    // ----------------------------------------------------------------------
    function automatic word_t rtype_word(input funct_t fn, input reg_addr_t rd,
                                         input reg_addr_t rs, input reg_addr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t itype_word(input opcode_t op, input reg_addr_t rs,
                                         input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic close_row(input int start, input reg_addr_t reg_addr, input word_t reg_val,
                             input logic mem_chk, input logic [4:0] mem_addr,
                             input word_t mem_val, input word_t halt_pc);
        rows.push_back('{8'(start), 8'(prog.size() - start), reg_addr, reg_val,
                         mem_chk, mem_addr, mem_val, halt_pc});
    endtask

    // Sets r1 and r2 and puts r1 op r2 into r3 with the halt at word 5
    task automatic alu_case(input funct_t fn, input logic [15:0] a, input logic [15:0] b,
                            input word_t exp);
        int start;
        start = prog.size();
        prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd1, a));
        prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd2, b));
        prog.push_back(32'h0);                      // Keep r2 three slots ahead
        prog.push_back(32'h0);
        prog.push_back(rtype_word(fn, 5'd3, 5'd1, 5'd2));
        prog.push_back(HALT_WORD);
        close_row(start, 5'd3, exp, 1'b0, 5'd0, 32'd0, 32'd20);
    endtask

    task automatic build_table();
        word_t rnd_a;
        word_t rnd_b;
        int    val_a;
        int    val_b;
        int    start;
        alu_case(FN_ADD, 16'd7, 16'hfffd, 32'd4);   // 7 + -3
        alu_case(FN_SUB, 16'd7, 16'hfffd, 32'd10);
        alu_case(FN_AND, 16'd12, 16'd10, 32'd8);
        alu_case(FN_OR, 16'd12, 16'd10, 32'd14);
        alu_case(FN_SLT, 16'hfffb, 16'd3, 32'd1);   // -5 < 3
        alu_case(FN_SLT, 16'd3, 16'hfffb, 32'd0);
        // Store to byte 12 and load it back into r4
        start = prog.size();
        prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd1, 16'h1234));
        prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd2, 16'd8));
        prog.push_back(32'h0);
        prog.push_back(32'h0);
        prog.push_back(itype_word(OP_SW, 5'd2, 5'd1, 16'd4));
        prog.push_back(itype_word(OP_LW, 5'd2, 5'd4, 16'd4));
        prog.push_back(HALT_WORD);
        close_row(start, 5'd4, 32'h1234, 1'b1, 5'd3, 32'h1234, 32'd24);
        // Taken beq to word 6 runs its delay slot and skips word 5
        start = prog.size();
        prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd1, 16'd5));
        prog.push_back(32'h0);
        prog.push_back(32'h0);
        prog.push_back(itype_word(OP_BEQ, 5'd1, 5'd1, 16'd2));
        prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd6, 16'd11));
        prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd6, 16'd99));
        prog.push_back(HALT_WORD);
        close_row(start, 5'd6, 32'd11, 1'b0, 5'd0, 32'd0, 32'd24);
        // Not-taken bne runs its delay slot and falls through
        start = prog.size();
        prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd1, 16'd5));
        prog.push_back(32'h0);
        prog.push_back(32'h0);
        prog.push_back(itype_word(OP_BNE, 5'd1, 5'd1, 16'd3));
        prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd7, 16'd21));
        prog.push_back(32'h0);
        prog.push_back(HALT_WORD);
        close_row(start, 5'd7, 32'd21, 1'b0, 5'd0, 32'd0, 32'd24);
        // Write to r0 is dropped
        start = prog.size();
        prog.push_back(itype_word(OP_ADDI, 5'd0, 5'd0, 16'd9));
        prog.push_back(32'h0);
        prog.push_back(32'h0);
        prog.push_back(HALT_WORD);
        close_row(start, 5'd0, 32'd0, 1'b0, 5'd0, 32'd0, 32'd12);
        // Random immediates checked against their signed integer sum and difference
        rnd_a = $random(seed);
        rnd_b = $random(seed);
        val_a = $signed(rnd_a[15:0]);
        val_b = $signed(rnd_b[15:0]);
        alu_case(FN_ADD, rnd_a[15:0], rnd_b[15:0], word_t'(val_a + val_b));
        alu_case(FN_SUB, rnd_a[15:0], rnd_b[15:0], word_t'(val_a - val_b));
    endtask

    // ----------------------------------------------------------------------
    // Load, run and check
    // ----------------------------------------------------------------------
    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic load_program(input int start, input int count);
        word_t w;
        int    i;
        int    b;
        @(negedge clock);
        run      = 1'b0;
        pc_reset = 1'b1;                            // Load pointer back to word 0
        @(negedge clock);
        pc_reset = 1'b0;
        for (i = 0; i < count; i++) begin
            w = prog[start + i];
            for (b = 0; b < 4; b++) begin
                load_valid = 1'b1;
                load_byte  = w[31 - 8*b -: 8];      // MSB first
                @(negedge clock);
            end
        end
        load_valid = 1'b0;
        repeat (2) @(negedge clock);                // Last word reaches imem
        pc_reset = 1'b1;
        @(negedge clock);
        pc_reset = 1'b0;
    endtask

    task automatic run_row(input test_row_t row);
        int cycles;
        load_program(row.start, row.count);
        check_word("o_is_program_end", {31'd0, is_program_end}, 32'd0);
        run    = 1'b1;
        cycles = 0;
        while (!is_program_end && cycles < END_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        assert (is_program_end) else begin
            $display("timeout waiting for program end at %0t ns", $time);
            err_cnt++;
        end
        repeat (4) @(negedge clock);                // Drain the pipe
        run            = 1'b0;
        debug_reg_addr = row.reg_addr;
        debug_mem_addr = row.mem_addr;
        @(negedge clock);
        check_word("o_debug_read_reg", debug_read_reg, row.reg_val);
        if (row.mem_chk) begin
            check_word("o_debug_read_mem", debug_read_mem, row.mem_val);
        end
        check_word("o_debug_read_pc", debug_read_pc, row.halt_pc);
    endtask

    initial begin
        int i;
        int err_before;
        seed           = 32'h5223;
        rst            = 1'b1;
        run            = 1'b0;
        pc_reset       = 1'b0;
        load_valid     = 1'b0;
        load_byte      = 8'h00;
        debug_reg_addr = 5'd0;
        debug_mem_addr = 5'd0;
        build_table();
        repeat (4) @(negedge clock);
        rst = 1'b0;
        @(negedge clock);
        check_word("o_is_program_end", {31'd0, is_program_end}, 32'd0);
        check_word("o_debug_read_pc", debug_read_pc, 32'd0);
        for (i = 0; i < rows.size(); i++) begin
            err_before = err_cnt;
            run_row(rows[i]);
            if (err_cnt == err_before) begin
                pass_cnt++;
                $display("test %0d passed", i);
            end else begin
                fail_cnt++;
                $display("test %0d failed", i);
            end
        end
        $display("tests passed: %0d, failed: %0d, assertion errors: %0d",
                 pass_cnt, fail_cnt, dut.u_sva.assert_errors);
        if (err_cnt == 0 && dut.u_sva.assert_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_mips_sva.sv ====
`timescale 1ns/1ps

module tb_mips_sva (
    input logic                i_clock,
    input logic                i_rst,
    input logic                i_run,
    input logic                i_pc_reset,
    input mips_pkg::reg_addr_t i_debug_reg_addr,
    input mips_pkg::word_t     i_debug_read_reg,
    input mips_pkg::word_t     i_pc,
    input logic                i_is_end
);

    int assert_errors = 0;

    // Frozen core keeps its PC
    pc_hold: assert property (@(posedge i_clock)
        (!i_run && !i_rst && !i_pc_reset) |=> $stable(i_pc))
        else begin
            $error("PC changed on an edge with run low");
            assert_errors++;
        end

    // Halt flag is sticky until a reset
    end_sticky: assert property (@(posedge i_clock)
        (i_is_end && !i_rst && !i_pc_reset) |=> i_is_end)
        else begin
            $error("program end flag dropped without a reset");
            assert_errors++;
        end

    // r0 always reads zero
    r0_zero: assert property (@(posedge i_clock)
        (i_debug_reg_addr == '0) |-> (i_debug_read_reg == '0))
        else begin
            $error("register 0 read back nonzero");
            assert_errors++;
        end

endmodule

bind mips tb_mips_sva u_sva (
    .i_clock          (i_clock),
    .i_rst            (i_rst),
    .i_run            (i_run),
    .i_pc_reset       (i_pc_reset),
    .i_debug_reg_addr (i_debug_reg_addr),
    .i_debug_read_reg (o_debug_read_reg),
    .i_pc             (o_debug_read_pc),
    .i_is_end         (o_is_program_end)
);

// ==== rtl/mips.sv ====
`timescale 1ns/1ps

module mips #(
    parameter int NB_IMEM_ADDR = 6,
    parameter int NB_DMEM_ADDR = 5
) (
    input  logic                    i_clock,
    input  logic                    i_rst,
    input  logic                    i_run,              // Freezes every stage when low
    input  logic                    i_pc_reset,
    input  logic                    i_load_valid,
    input  logic [7:0]              i_load_byte,
    input  mips_pkg::reg_addr_t     i_debug_reg_addr,
    input  logic [NB_DMEM_ADDR-1:0] i_debug_mem_addr,
    output mips_pkg::word_t         o_debug_read_reg,
    output mips_pkg::word_t         o_debug_read_mem,
    output mips_pkg::word_t         o_debug_read_pc,
    output logic                    o_is_program_end
);
    import mips_pkg::*;

    imem_wr_t imem_wr;
    if_id_t   if_id_d;
    if_id_t   if_id_q;
    id_ex_t   id_ex_d;
    id_ex_t   id_ex_q;
    ex_mem_t  ex_mem_d;
    ex_mem_t  ex_mem_q;
    mem_wb_t  mem_wb_d;
    mem_wb_t  mem_wb_q;
    logic     branch_taken;
    word_t    branch_target;
    word_t    load_data;
    word_t    wb_data;

    // ----------------------------------------------------------------------
    // Stages
    // ----------------------------------------------------------------------
    program_loader u_program_loader (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_load_valid (i_load_valid),
        .i_load_byte  (i_load_byte),
        .o_imem_wr    (imem_wr)
    );

    instruction_fetch #(
        .NB_IMEM_ADDR (NB_IMEM_ADDR)
    ) u_instruction_fetch (
        .i_clock         (i_clock),
        .i_rst           (i_rst),
        .i_pc_reset      (i_pc_reset),
        .i_run           (i_run),
        .i_imem_wr       (imem_wr),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .o_if_id         (if_id_d),
        .o_pc            (o_debug_read_pc),
        .o_is_end        (o_is_program_end)
    );

    instruction_decode u_instruction_decode (
        .i_clock          (i_clock),
        .i_if_id          (if_id_q),
        .i_wb_write       (mem_wb_q.reg_write),
        .i_wb_dest        (mem_wb_q.dest),
        .i_wb_data        (wb_data),
        .i_debug_reg_addr (i_debug_reg_addr),
        .o_id_ex          (id_ex_d),
        .o_branch_taken   (branch_taken),
        .o_branch_target  (branch_target),
        .o_debug_read_reg (o_debug_read_reg)
    );

    execution u_execution (
        .i_id_ex  (id_ex_q),
        .o_ex_mem (ex_mem_d)
    );

    memory_access #(
        .NB_DMEM_ADDR (NB_DMEM_ADDR)
    ) u_memory_access (
        .i_clock          (i_clock),
        .i_ex_mem         (ex_mem_q),
        .i_debug_mem_addr (i_debug_mem_addr),
        .o_load_data      (load_data),
        .o_debug_read_mem (o_debug_read_mem)
    );

    // MEM/WB input built from EX/MEM plus the load result
    always_comb begin
        mem_wb_d.reg_write  = ex_mem_q.reg_write;
        mem_wb_d.mem_to_reg = ex_mem_q.mem_to_reg;
        mem_wb_d.alu_data   = ex_mem_q.alu_data;
        mem_wb_d.load_data  = load_data;
        mem_wb_d.dest       = ex_mem_q.dest;
    end

    // ----------------------------------------------------------------------
    // Pipeline registers, all advance together on run
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_rst || i_pc_reset) begin
            if_id_q  <= '0;             // Cleared stages act as NOPs
            id_ex_q  <= '0;
            ex_mem_q <= '0;
            mem_wb_q <= '0;
        end else if (i_run) begin
            if_id_q  <= if_id_d;
            id_ex_q  <= id_ex_d;
            ex_mem_q <= ex_mem_d;
            mem_wb_q <= mem_wb_d;
        end
    end

    // Write-back select
    assign wb_data = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_data;

endmodule

// ==== rtl/memory_access.sv ====
`timescale 1ns/1ps

module memory_access #(
    parameter int NB_DMEM_ADDR = 5                  // Word address bits
) (
    input  logic                    i_clock,
    input  mips_pkg::ex_mem_t       i_ex_mem,
    input  logic [NB_DMEM_ADDR-1:0] i_debug_mem_addr,
    output mips_pkg::word_t         o_load_data,
    output mips_pkg::word_t         o_debug_read_mem
);
    import mips_pkg::*;

    localparam int N_DMEM_WORDS = 2 ** NB_DMEM_ADDR;

    word_t                   dmem [N_DMEM_WORDS];
    logic [NB_DMEM_ADDR-1:0] word_addr;

    // Byte address to word index, low two bits ignored
    assign word_addr = i_ex_mem.alu_data[NB_DMEM_ADDR+1:2];

    // ----------------------------------------------------------------------
    // Store port
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_ex_mem.mem_write) begin
            dmem[word_addr] <= i_ex_mem.store_data;     // Full word only
        end
    end

    // Load and debug reads, both combinational
    assign o_load_data      = i_ex_mem.mem_read ? dmem[word_addr] : '0;
    assign o_debug_read_mem = dmem[i_debug_mem_addr];

endmodule

// ==== rtl/execution.sv ====
`timescale 1ns/1ps

module execution (
    input  mips_pkg::id_ex_t  i_id_ex,
    output mips_pkg::ex_mem_t o_ex_mem
);
    import mips_pkg::*;

    word_t opnd_a;
    word_t opnd_b;
    word_t alu_result;

    assign opnd_a = i_id_ex.ra_data;
    assign opnd_b = i_id_ex.ctrl.alu_src ? i_id_ex.imm : i_id_ex.rb_data;

    // ----------------------------------------------------------------------
    // ALU
    // ----------------------------------------------------------------------
    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_ADD: alu_result = opnd_a + opnd_b;
            ALU_SUB: alu_result = opnd_a - opnd_b;
            ALU_AND: alu_result = opnd_a & opnd_b;
            ALU_OR:  alu_result = opnd_a | opnd_b;
            ALU_SLT: begin
                // Signed compare, result is 0 or 1
                alu_result = ($signed(opnd_a) < $signed(opnd_b)) ? 32'd1 : 32'd0;
            end
            default: alu_result = opnd_a + opnd_b;
        endcase
    end

    // Pass memory and WB controls on
    always_comb begin
        o_ex_mem.mem_read   = i_id_ex.ctrl.mem_read;
        o_ex_mem.mem_write  = i_id_ex.ctrl.mem_write;
        o_ex_mem.mem_to_reg = i_id_ex.ctrl.mem_to_reg;
        o_ex_mem.reg_write  = i_id_ex.ctrl.reg_write;
        o_ex_mem.alu_data   = alu_result;
        o_ex_mem.store_data = i_id_ex.rb_data;          // rt value for sw
        o_ex_mem.dest       = i_id_ex.ctrl.reg_dst ? i_id_ex.rd : i_id_ex.rt;
    end

endmodule

// ==== rtl/instruction_decode.sv ====
`timescale 1ns/1ps

module instruction_decode (
    input  logic                i_clock,
    input  mips_pkg::if_id_t    i_if_id,
    input  logic                i_wb_write,
    input  mips_pkg::reg_addr_t i_wb_dest,
    input  mips_pkg::word_t     i_wb_data,
    input  mips_pkg::reg_addr_t i_debug_reg_addr,
    output mips_pkg::id_ex_t    o_id_ex,
    output logic                o_branch_taken,
    output mips_pkg::word_t     o_branch_target,
    output mips_pkg::word_t     o_debug_read_reg
);
    import mips_pkg::*;

    word_t     regs [32];       // Register file
    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     imm;
    word_t     ra_data;
    word_t     rb_data;
    ctrl_t     ctrl;
    logic      is_beq;
    logic      is_bne;

    // Read with zero register and write-through of the WB value
    function automatic word_t read_reg(input reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (i_wb_write && (i_wb_dest == addr)) begin
            value = i_wb_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    // ----------------------------------------------------------------------
    // Register file
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_wb_write && (i_wb_dest != '0)) begin
            regs[i_wb_dest] <= i_wb_data;           // r0 never stored
        end
    end

    // Instruction fields
    assign opcode = i_if_id.instr[31:26];
    assign rs     = i_if_id.instr[25:21];
    assign rt     = i_if_id.instr[20:16];
    assign rd     = i_if_id.instr[15:11];
    assign funct  = i_if_id.instr[5:0];
    assign imm    = {{16{i_if_id.instr[15]}}, i_if_id.instr[15:0]};

    always_comb begin
        ra_data          = read_reg(rs);
        rb_data          = read_reg(rt);
        o_debug_read_reg = read_reg(i_debug_reg_addr);
    end

    // ----------------------------------------------------------------------
    // Control decode
    // ----------------------------------------------------------------------
    always_comb begin
        ctrl   = '0;                                // Unknown encodings become a NOP
        is_beq = 1'b0;
        is_bne = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_dst   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADD:  ctrl.alu_op = ALU_ADD;
                    FN_SUB:  ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: ctrl        = '0;      // Includes the all-zero NOP
                endcase
            end
            OP_ADDI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_LW: begin
                ctrl.alu_src    = 1'b1;             // Base plus offset
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            OP_SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OP_BEQ:  is_beq = 1'b1;
            OP_BNE:  is_bne = 1'b1;
            default: ctrl   = '0;
        endcase
    end

    // Branch resolved here, one delay slot follows
    assign o_branch_taken  = (is_beq && (ra_data == rb_data)) ||
                             (is_bne && (ra_data != rb_data));
    assign o_branch_target = i_if_id.pc_plus4 + {imm[29:0], 2'b00};

    always_comb begin
        o_id_ex.ctrl    = ctrl;
        o_id_ex.ra_data = ra_data;
        o_id_ex.rb_data = rb_data;
        o_id_ex.imm     = imm;
        o_id_ex.rt      = rt;
        o_id_ex.rd      = rd;
    end

endmodule

// ==== rtl/instruction_fetch.sv ====
`timescale 1ns/1ps

module instruction_fetch #(
    parameter int NB_IMEM_ADDR = 6                  // Word address bits
) (
    input  logic               i_clock,
    input  logic               i_rst,
    input  logic               i_pc_reset,
    input  logic               i_run,
    input  mips_pkg::imem_wr_t i_imem_wr,
    input  logic               i_branch_taken,     // From decode, same cycle
    input  mips_pkg::word_t    i_branch_target,
    output mips_pkg::if_id_t   o_if_id,
    output mips_pkg::word_t    o_pc,
    output logic               o_is_end
);
    import mips_pkg::*;

    localparam int N_IMEM_WORDS = 2 ** NB_IMEM_ADDR;

    word_t                   imem [N_IMEM_WORDS];
    logic [NB_IMEM_ADDR-1:0] load_ptr;              // Next word written by the loader
    word_t                   pc;
    word_t                   pc_plus4;
    word_t                   instr;
    logic                    is_halt;
    logic                    halted;

    // ----------------------------------------------------------------------
    // Program load port
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (i_imem_wr.valid) begin
            imem[load_ptr] <= i_imem_wr.data;
        end
    end

    // Restart loading at word 0 on either reset
    always_ff @(posedge i_clock) begin
        if (i_rst || i_pc_reset) begin
            load_ptr <= '0;
        end else if (i_imem_wr.valid) begin
            load_ptr <= load_ptr + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Fetch and next PC
    // ----------------------------------------------------------------------
    assign instr    = imem[pc[NB_IMEM_ADDR+1:2]];  // Word addressed by PC
    assign pc_plus4 = pc + 32'd4;
    assign is_halt  = (instr == HALT_WORD);

    always_ff @(posedge i_clock) begin
        if (i_rst || i_pc_reset) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (i_run) begin
            if (is_halt) begin
                halted <= 1'b1;                     // PC parks on the halt word
            end else if (i_branch_taken) begin
                pc <= i_branch_target;              // Delay slot already fetched
            end else begin
                pc <= pc_plus4;
            end
        end
    end

    // Halt word travels down the pipe as a NOP
    always_comb begin
        o_if_id.pc_plus4 = pc_plus4;
        o_if_id.instr    = is_halt ? '0 : instr;
    end

    assign o_pc     = pc;
    assign o_is_end = halted;   // Sticky until a reset

endmodule

// ==== rtl/program_loader.sv ====
`timescale 1ns/1ps

module program_loader (
    input  logic               i_clock,
    input  logic               i_rst,
    input  logic               i_load_valid,   // One cycle per byte
    input  logic [7:0]         i_load_byte,
    output mips_pkg::imem_wr_t o_imem_wr
);

    logic [1:0]  byte_cnt;      // Position inside the current word
    logic [23:0] byte_shift;    // First three bytes, oldest on top
    logic        word_done;

    assign word_done = i_load_valid && (byte_cnt == 2'd3);

    // Byte counter and write strobe
    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            byte_cnt        <= '0;
            o_imem_wr.valid <= 1'b0;
        end else begin
            o_imem_wr.valid <= word_done;                  // High one cycle after 4th byte
            if (i_load_valid) begin
                byte_cnt <= byte_cnt + 2'd1;               // Wraps modulo four
            end
        end
    end

    // Byte assembly, first byte ends up most significant
    always_ff @(posedge i_clock) begin
        if (i_load_valid) begin
            byte_shift <= {byte_shift[15:0], i_load_byte};
        end
        if (word_done) begin
            o_imem_wr.data <= {byte_shift, i_load_byte};
        end
    end

endmodule

// ==== rtl/mips_pkg.sv ====
package mips_pkg;

    // ----------------------------------------------------------------------
    // Widths and plain vector types
    // ----------------------------------------------------------------------
    localparam int NB_DATA = 32;                // Datapath width

    typedef logic [NB_DATA-1:0] word_t;         // Data, instruction and PC values
    typedef logic [4:0]         reg_addr_t;     // Register number
    typedef logic [5:0]         opcode_t;       // instr[31:26]
    typedef logic [5:0]         funct_t;        // instr[5:0] of R-type
    typedef logic [2:0]         alu_op_t;       // Internal ALU operation code

    // ALU operation codes
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;         // Signed compare

    // ----------------------------------------------------------------------
    // MIPS encodings
    // ----------------------------------------------------------------------
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;

    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    localparam word_t HALT_WORD = 32'hffff_ffff;    // End of program marker

    // ----------------------------------------------------------------------
    // Control bundle and pipeline registers
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic    reg_dst;       // 1 = rd, 0 = rt
        logic    alu_src;       // 1 = immediate as operand B
        alu_op_t alu_op;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;    // WB takes load data
        logic    reg_write;
    } ctrl_t;

    typedef struct packed {
        word_t pc_plus4;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     ra_data;
        word_t     rb_data;
        word_t     imm;         // Sign extended
        reg_addr_t rt;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;
        logic      reg_write;
        word_t     alu_data;    // Result or byte address
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_to_reg;
        word_t     alu_data;
        word_t     load_data;
        reg_addr_t dest;
    } mem_wb_t;

    // Instruction memory write, address kept by fetch
    typedef struct packed {
        logic  valid;
        word_t data;
    } imem_wr_t;

endpackage
